//--- cu_setup.f
cu_setup_pkg.sv
cu_setup_input.sv
cu_setup_fsm.sv
cu_setup_read_engine.sv
cu_setup_request_fifo.sv
cu_setup.sv
tb_cu_setup.sv

//--- Makefile
# Verilator build and run for the compute-unit setup block

VERILATOR ?= verilator
TOP       ?= tb_cu_setup
RTL_TOP   ?= cu_setup
FILELIST  ?= cu_setup.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_cu_setup.sv
// ------------------------------
// The DUT is reset before every test because done is sticky
// Responses come back in request order after a random delay
// ------------------------------
`timescale 1ns/10ps

module tb_cu_setup;

    localparam int unsigned BEAT_BYTES      = 64;
    localparam int          RESET_CYCLES    = 16;
    localparam int          WAIT_LIMIT      = 2000;
    localparam int          NO_LIMIT        = 32'h7fff_ffff;
    localparam int          TOTAL_REQUESTS  = 10 + 5 + 7 + 60 + 8 + 0;
    localparam int          WATCHDOG_CYCLES = TOTAL_REQUESTS * 40 + 2000;

    logic                        ap_clk = 1'b0;
    logic                        areset_cu_setup;
    cu_setup_pkg::descriptor_t   descriptor_in;
    logic                        cu_flush;
    cu_setup_pkg::response_t     response_in = '0;
    logic                        request_ready = 1'b0;
    cu_setup_pkg::request_t      request_out;
    logic                        done_out;

    // Expected requests in arrival order
    cu_setup_pkg::request_payload_t exp_q [$];
    int unsigned                    due_q [$];
    int unsigned                    env_cycle = 0;

    int req_seen     = 0;
    int resp_sent    = 0;
    int resp_limit   = NO_LIMIT;
    logic ready_mode  = 1'b0;
    logic ready_block = 1'b0;

    int value_errors = 0;
    int other_errors = 0;

    always #50 ap_clk = ~ap_clk;

    cu_setup #(
        .FIFO_DEPTH  (32),
        .PROG_THRESH (16),
        .BEAT_BYTES  (BEAT_BYTES)
    ) dut (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .descriptor_in   (descriptor_in),
        .cu_flush        (cu_flush),
        .response_in     (response_in),
        .request_ready   (request_ready),
        .request_out     (request_out),
        .done_out        (done_out)
    );

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_request(input cu_setup_pkg::request_payload_t got,
                                 input cu_setup_pkg::request_payload_t exp);
        if (got !== exp) begin
            $display("[FAIL] request_out.payload got %h exp %h (index %h/%h, address %h/%h)",
                     got, exp, got.index, exp.index, got.address, exp.address);
            value_errors++;
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h exp %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %s got %h exp %h", name, got, exp);
            value_errors++;
        end
    endtask

    // Expected request from the address and flush rules
    function automatic cu_setup_pkg::request_payload_t make_request(input int unsigned idx,
                                                                    input logic flush);
        cu_setup_pkg::request_payload_t p;
        p.cmd        = cu_setup_pkg::CMD_MEM_READ;
        p.address    = idx * BEAT_BYTES;
        p.index      = idx;
        p.flush_mode = flush;
        return p;
    endfunction

    // Flush size in the upper word and flush enable just below the program size
    function automatic cu_setup_pkg::descriptor_t make_descriptor(input int unsigned prog_size,
                                                                  input int unsigned flush_size,
                                                                  input logic flush_en);
        cu_setup_pkg::descriptor_t d;
        d.valid    = 1'b1;
        d.buffer_9 = {flush_size[31:0], prog_size[28:0], flush_en, 2'b00};
        return d;
    endfunction

    // ------------------------------
    // Responder and ready driver
    // ------------------------------
    initial begin : env
        cu_setup_pkg::request_payload_t exp_payload;
        void'($urandom(32'ha944_c117));
        forever begin
            @(negedge ap_clk);
            if (areset_cu_setup) begin
                due_q.delete();
                req_seen      <= 0;
                resp_sent     <= 0;
                request_ready = 1'b0;
                response_in   = '0;
            end else begin
                env_cycle = env_cycle + 1;
                if (request_out.valid === 1'b1) begin
                    req_seen <= req_seen + 1;
                    if (exp_q.size() == 0) begin
                        $display("Unexpected request with index %h after the expected set",
                                 request_out.payload.index);
                        other_errors++;
                    end else begin
                        exp_payload = exp_q.pop_front();
                        check_request(request_out.payload, exp_payload);
                    end
                    due_q.push_back(env_cycle + 1 + ($urandom % 8));
                end
                response_in = '0;
                if (due_q.size() > 0 && due_q[0] <= env_cycle && resp_sent < resp_limit) begin
                    due_q.delete(0);
                    response_in.valid = 1'b1;
                    response_in.data  = env_cycle;
                    resp_sent <= resp_sent + 1;
                end
                if (ready_block) begin
                    request_ready = 1'b0;
                end else if (ready_mode) begin
                    request_ready = (($urandom % 4) != 0);
                end else begin
                    request_ready = 1'b1;
                end
            end
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic reset_dut();
        @(negedge ap_clk);
        areset_cu_setup = 1'b1;
        descriptor_in   = '0;
        cu_flush        = 1'b0;
        resp_limit  <= NO_LIMIT;
        ready_mode  <= 1'b0;
        ready_block <= 1'b0;
        repeat (RESET_CYCLES) @(negedge ap_clk);
        exp_q.delete();
        areset_cu_setup = 1'b0;
        repeat (4) @(negedge ap_clk);
    endtask

    task automatic expect_phase(input int n, input logic flush);
        for (int i = 0; i < n; i++) begin
            exp_q.push_back(make_request(i, flush));
        end
    endtask

    // Word stays on the bus after valid drops
    task automatic send_descriptor(input int unsigned prog_size, input int unsigned flush_size,
                                   input logic flush_en);
        @(negedge ap_clk);
        descriptor_in = make_descriptor(prog_size, flush_size, flush_en);
        @(negedge ap_clk);
        descriptor_in.valid = 1'b0;
    endtask

    task automatic wait_responses(input int n);
        int waited;
        waited = 0;
        while (resp_sent < n && waited < WAIT_LIMIT) begin
            @(negedge ap_clk);
            waited++;
        end
        if (resp_sent < n) begin
            $display("Timed out waiting for %0d responses, only %0d sent", n, resp_sent);
            other_errors++;
        end
    endtask

    task automatic wait_requests(input int n);
        int waited;
        waited = 0;
        while (req_seen < n && waited < WAIT_LIMIT) begin
            @(negedge ap_clk);
            waited++;
        end
        if (req_seen < n) begin
            $display("Timed out waiting for %0d requests, only %0d seen", n, req_seen);
            other_errors++;
        end
    endtask

    task automatic hold_done_low(input int cycles);
        repeat (cycles) begin
            @(negedge ap_clk);
            check_level("done_out", done_out, 1'b0);
        end
    endtask

    // Done must follow the last response and then stay high
    task automatic wait_done(input int total);
        int waited;
        waited = 0;
        while (done_out !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge ap_clk);
            waited++;
        end
        if (done_out !== 1'b1) begin
            $display("done_out did not rise within %0d cycles", WAIT_LIMIT);
            other_errors++;
        end else begin
            check_count("responses_before_done", resp_sent, total);
            check_count("requests_seen", req_seen, total);
            check_count("requests_missing", exp_q.size(), 0);
            repeat (20) begin
                @(negedge ap_clk);
                check_level("done_out", done_out, 1'b1);
            end
        end
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic test_reset_idle();
        $display("Test: idle after reset");
        reset_dut();
        repeat (100) begin
            @(negedge ap_clk);
            check_level("request_out.valid", request_out.valid, 1'b0);
            check_level("done_out", done_out, 1'b0);
        end
    endtask

    task automatic test_program_only();
        $display("Test: program phase only, size 10");
        reset_dut();
        expect_phase(10, 1'b0);
        send_descriptor(10, 0, 1'b0);
        wait_done(10);
    endtask

    task automatic test_program_flush();
        $display("Test: program 5 then flush 7");
        reset_dut();
        expect_phase(5, 1'b0);
        expect_phase(7, 1'b1);
        send_descriptor(5, 7, 1'b1);
        wait_responses(5);
        hold_done_low(200);
        check_count("requests_seen", req_seen, 5);
        cu_flush = 1'b1;
        wait_done(12);
    endtask

    task automatic test_back_pressure();
        $display("Test: back-pressure, size 60");
        reset_dut();
        expect_phase(60, 1'b0);
        ready_mode <= 1'b1;
        send_descriptor(60, 0, 1'b0);
        wait_requests(20);
        ready_block <= 1'b1;
        repeat (100) @(negedge ap_clk);
        ready_block <= 1'b0;
        wait_done(60);
        ready_mode <= 1'b0;
    endtask

    task automatic test_withheld_response();
        $display("Test: last response withheld, size 8");
        reset_dut();
        expect_phase(8, 1'b0);
        resp_limit <= 7;
        send_descriptor(8, 0, 1'b0);
        wait_responses(7);
        wait_requests(8);
        hold_done_low(300);
        resp_limit <= NO_LIMIT;
        wait_done(8);
    endtask

    task automatic test_size_zero();
        $display("Test: size zero");
        reset_dut();
        send_descriptor(0, 0, 1'b0);
        wait_done(0);
    endtask

    // ------------------------------
    // Main sequence and watchdog
    // ------------------------------
    initial begin
        areset_cu_setup = 1'b1;
        descriptor_in   = '0;
        cu_flush        = 1'b0;
        test_reset_idle();
        test_program_only();
        test_program_flush();
        test_back_pressure();
        test_withheld_response();
        test_size_zero();
        $display("Errors: value mismatches %0d, other failures %0d",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish",
                 WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- cu_setup.sv
// ------------------------------
// PROG_THRESH must stay below FIFO_DEPTH. Reset is taken one cycle late
// ------------------------------
`timescale 1ns/10ps

module cu_setup #(
    parameter int          FIFO_DEPTH  = 32,
    parameter int          PROG_THRESH = 16,
    parameter int unsigned BEAT_BYTES  = 64
) (
    input  logic                      ap_clk,
    input  logic                      areset_cu_setup,
    input  cu_setup_pkg::descriptor_t descriptor_in,
    input  logic                      cu_flush,
    input  cu_setup_pkg::response_t   response_in,
    input  logic                      request_ready,
    output cu_setup_pkg::request_t    request_out,
    output logic                      done_out
);

    logic rst;

    cu_setup_pkg::setup_params_t params;
    logic                        params_valid;
    logic                        flush_req;
    logic                        response_strobe;
    cu_setup_pkg::phase_cmd_t    phase_cmd;
    cu_setup_pkg::request_t      wr_req;
    logic                        engine_busy;
    logic                        engine_done;
    logic                        prog_full;
    logic                        fifo_empty;

    // Local reset copy
    always_ff @(posedge ap_clk) begin
        rst <= areset_cu_setup;
    end

    // ------------------------------
    // Input side
    // ------------------------------
    cu_setup_input u_input (
        .ap_clk          (ap_clk),
        .rst             (rst),
        .descriptor_in   (descriptor_in),
        .cu_flush        (cu_flush),
        .response_in     (response_in),
        .params          (params),
        .params_valid    (params_valid),
        .flush_req       (flush_req),
        .response_strobe (response_strobe)
    );

    cu_setup_fsm u_fsm (
        .ap_clk          (ap_clk),
        .rst             (rst),
        .params          (params),
        .params_valid    (params_valid),
        .flush_req       (flush_req),
        .response_strobe (response_strobe),
        .engine_busy     (engine_busy),
        .engine_done     (engine_done),
        .prog_full       (prog_full),
        .fifo_empty      (fifo_empty),
        .phase_cmd       (phase_cmd),
        .done_out        (done_out)
    );

    // ------------------------------
    // Request path
    // ------------------------------
    cu_setup_read_engine #(
        .BEAT_BYTES (BEAT_BYTES)
    ) u_read_engine (
        .ap_clk      (ap_clk),
        .rst         (rst),
        .phase_cmd   (phase_cmd),
        .prog_full   (prog_full),
        .wr_req      (wr_req),
        .engine_busy (engine_busy),
        .engine_done (engine_done)
    );

    cu_setup_request_fifo #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .PROG_THRESH (PROG_THRESH)
    ) u_request_fifo (
        .ap_clk        (ap_clk),
        .rst           (rst),
        .wr_req        (wr_req),
        .request_ready (request_ready),
        .request_out   (request_out),
        .prog_full     (prog_full),
        .fifo_empty    (fifo_empty)
    );

endmodule

//--- cu_setup_request_fifo.sv
// ------------------------------
// Output data lags the pop by one cycle. The writer must hold off
// once prog_full is seen, there is no full handshake
// ------------------------------
`timescale 1ns/10ps

module cu_setup_request_fifo #(
    parameter int FIFO_DEPTH  = 32,
    parameter int PROG_THRESH = 16
) (
    input  logic                   ap_clk,
    input  logic                   rst,
    input  cu_setup_pkg::request_t wr_req,
    input  logic                   request_ready,
    output cu_setup_pkg::request_t request_out,
    output logic                   prog_full,
    output logic                   fifo_empty
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    cu_setup_pkg::request_payload_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    assign full       = (count == CNT_W'(FIFO_DEPTH));
    assign fifo_empty = (count == '0);
    assign prog_full  = (count >= CNT_W'(PROG_THRESH));
    assign push       = wr_req.valid;
    assign pop        = request_ready && !fifo_empty;

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_req.payload;
        end
    end

    // ------------------------------
    // Registered read port
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            request_out.valid <= 1'b0;
        end else begin
            request_out.valid <= pop;
        end
    end

    always_ff @(posedge ap_clk) begin
        request_out.payload <= mem[rd_ptr];
    end

    // Engine must stop on prog_full well before the FIFO fills
    a_no_write_full : assert property (
        @(posedge ap_clk) disable iff (rst)
        wr_req.valid |-> !full
    );

endmodule

//--- cu_setup_read_engine.sv
// ------------------------------
// One read per cycle at most, addresses are index times BEAT_BYTES
// and wrap at SIZE_WIDTH bits
// ------------------------------
`timescale 1ns/10ps

module cu_setup_read_engine #(
    parameter int unsigned BEAT_BYTES = 64
) (
    input  logic                     ap_clk,
    input  logic                     rst,
    input  cu_setup_pkg::phase_cmd_t phase_cmd,
    input  logic                     prog_full,
    output cu_setup_pkg::request_t   wr_req,
    output logic                     engine_busy,
    output logic                     engine_done
);

    logic [cu_setup_pkg::SIZE_WIDTH-1:0] index;
    logic [cu_setup_pkg::SIZE_WIDTH-1:0] remaining;
    logic                                flush_mode;

    // ------------------------------
    // Phase counters
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            index       <= '0;
            remaining   <= '0;
            flush_mode  <= 1'b0;
            engine_busy <= 1'b0;
            engine_done <= 1'b0;
        end else if (phase_cmd.start) begin
            index       <= '0;
            remaining   <= phase_cmd.size;
            flush_mode  <= phase_cmd.flush_mode;
            // Empty phase is finished on arrival
            engine_busy <= (phase_cmd.size != '0);
            engine_done <= (phase_cmd.size == '0);
        end else if (wr_req.valid) begin
            index     <= index + 1'b1;
            remaining <= remaining - 1'b1;
            if (remaining == 1) begin
                engine_busy <= 1'b0;
                engine_done <= 1'b1;
            end
        end
    end

    // ------------------------------
    // Request to the FIFO
    // ------------------------------
    always_comb begin
        wr_req.valid              = engine_busy && !prog_full;
        wr_req.payload.cmd        = cu_setup_pkg::CMD_MEM_READ;
        wr_req.payload.address    = index * BEAT_BYTES;
        wr_req.payload.index      = index;
        wr_req.payload.flush_mode = flush_mode;
    end

    // Busy flag and remaining count must agree
    a_no_idle_write : assert property (
        @(posedge ap_clk) disable iff (rst)
        wr_req.valid |-> remaining != '0
    );

endmodule

//--- cu_setup_fsm.sv
// ------------------------------
// Runs once per reset. Done is sticky and only reset clears it
// ------------------------------
`timescale 1ns/10ps

module cu_setup_fsm (
    input  logic                        ap_clk,
    input  logic                        rst,
    input  cu_setup_pkg::setup_params_t params,
    input  logic                        params_valid,
    input  logic                        flush_req,
    input  logic                        response_strobe,
    input  logic                        engine_busy,
    input  logic                        engine_done,
    input  logic                        prog_full,
    input  logic                        fifo_empty,
    output cu_setup_pkg::phase_cmd_t    phase_cmd,
    output logic                        done_out
);

    cu_setup_pkg::cu_setup_state_e state;
    cu_setup_pkg::cu_setup_state_e next_state;

    logic [cu_setup_pkg::SIZE_WIDTH-1:0] resp_count;
    logic                                phase_end;

    // All requests issued, all answered, nothing left queued
    assign phase_end = engine_done && (resp_count == '0) && fifo_empty;

    // ------------------------------
    // State machine
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            state <= cu_setup_pkg::RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            cu_setup_pkg::RESET: next_state = cu_setup_pkg::IDLE;
            cu_setup_pkg::IDLE: begin
                if (params_valid && !engine_busy) begin
                    next_state = cu_setup_pkg::REQ_START;
                end
            end
            cu_setup_pkg::REQ_START: next_state = cu_setup_pkg::REQ_BUSY;
            cu_setup_pkg::REQ_BUSY: begin
                if (phase_end) begin
                    next_state = cu_setup_pkg::REQ_DONE;
                end else if (prog_full) begin
                    next_state = cu_setup_pkg::REQ_PAUSE;
                end
            end
            cu_setup_pkg::REQ_PAUSE: begin
                if (!prog_full) begin
                    next_state = cu_setup_pkg::REQ_BUSY;
                end
            end
            cu_setup_pkg::REQ_DONE: begin
                // No flush phase requested, finish straight away
                if (!params.flush_enable) begin
                    next_state = cu_setup_pkg::FLUSH_DONE;
                end else if (flush_req) begin
                    next_state = cu_setup_pkg::FLUSH_START;
                end
            end
            cu_setup_pkg::FLUSH_START: next_state = cu_setup_pkg::FLUSH_BUSY;
            cu_setup_pkg::FLUSH_BUSY: begin
                if (phase_end) begin
                    next_state = cu_setup_pkg::FLUSH_DONE;
                end else if (prog_full) begin
                    next_state = cu_setup_pkg::FLUSH_PAUSE;
                end
            end
            cu_setup_pkg::FLUSH_PAUSE: begin
                if (!prog_full) begin
                    next_state = cu_setup_pkg::FLUSH_BUSY;
                end
            end
            cu_setup_pkg::FLUSH_DONE: next_state = cu_setup_pkg::FLUSH_DONE;
            default: next_state = cu_setup_pkg::RESET;
        endcase
    end

    // ------------------------------
    // Engine command
    // ------------------------------
    always_comb begin
        phase_cmd.start      = (state == cu_setup_pkg::REQ_START) ||
                               (state == cu_setup_pkg::FLUSH_START);
        phase_cmd.flush_mode = (state == cu_setup_pkg::FLUSH_START) ||
                               (state == cu_setup_pkg::FLUSH_BUSY)  ||
                               (state == cu_setup_pkg::FLUSH_PAUSE);
        phase_cmd.size       = phase_cmd.flush_mode ? params.flush_size
                                                    : params.program_size;
    end

    // Outstanding responses for the running phase
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            resp_count <= '0;
        end else if (phase_cmd.start) begin
            resp_count <= phase_cmd.size;
        end else if (response_strobe) begin
            resp_count <= resp_count - 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (rst) begin
            done_out <= 1'b0;
        end else begin
            done_out <= (state == cu_setup_pkg::FLUSH_DONE);
        end
    end

    // A response without a matching request would wrap the counter
    a_count_no_underflow : assert property (
        @(posedge ap_clk) disable iff (rst)
        response_strobe && !phase_cmd.start |-> resp_count != '0
    );

endmodule

//--- cu_setup_input.sv
// ------------------------------
// Every input is delayed by one cycle. The descriptor word is held
// between valid beats, so params stay put once valid drops
// ------------------------------
`timescale 1ns/10ps

module cu_setup_input (
    input  logic                       ap_clk,
    input  logic                       rst,
    input  cu_setup_pkg::descriptor_t  descriptor_in,
    input  logic                       cu_flush,
    input  cu_setup_pkg::response_t    response_in,
    output cu_setup_pkg::setup_params_t params,
    output logic                       params_valid,
    output logic                       flush_req,
    output logic                       response_strobe
);

    logic [cu_setup_pkg::BUFFER_9_WIDTH-1:0] buffer_9_q;

    // ------------------------------
    // Control bits
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            params_valid    <= 1'b0;
            flush_req       <= 1'b0;
            response_strobe <= 1'b0;
        end else begin
            params_valid    <= descriptor_in.valid;
            flush_req       <= cu_flush;
            response_strobe <= response_in.valid;
        end
    end

    // Descriptor word, captured on valid only
    always_ff @(posedge ap_clk) begin
        if (descriptor_in.valid) begin
            buffer_9_q <= descriptor_in.buffer_9;
        end
    end

    // ------------------------------
    // Decode
    // ------------------------------
    always_comb begin
        params.flush_enable = buffer_9_q[cu_setup_pkg::FLUSH_ENABLE_BIT];
        params.program_size = cu_setup_pkg::SIZE_WIDTH'(
            buffer_9_q[cu_setup_pkg::PROG_SIZE_MSB:cu_setup_pkg::PROG_SIZE_LSB]);
        params.flush_size   =
            buffer_9_q[cu_setup_pkg::FLUSH_SIZE_MSB:cu_setup_pkg::FLUSH_SIZE_LSB];
    end

    // A held descriptor must not be rewritten mid-run
    a_params_stable : assert property (
        @(posedge ap_clk) disable iff (rst)
        params_valid && $past(params_valid) |-> $stable(params)
    );

endmodule

//--- cu_setup_pkg.sv
// ------------------------------
// Types shared by the setup block. Program size is 29 bits wide in the
// descriptor and is zero-extended to SIZE_WIDTH on decode
// ------------------------------

package cu_setup_pkg;

    // ------------------------------
    // Widths and descriptor layout
    // ------------------------------
    parameter int BUFFER_9_WIDTH = 64;
    parameter int SIZE_WIDTH     = 32;
    parameter int DATA_WIDTH     = 32;

    // Bit positions inside buffer_9
    parameter int FLUSH_ENABLE_BIT = 2;
    parameter int PROG_SIZE_LSB    = 3;
    parameter int PROG_SIZE_MSB    = 31;
    parameter int FLUSH_SIZE_LSB   = 32;
    parameter int FLUSH_SIZE_MSB   = 63;

    // Memory command codes
    typedef enum logic [1:0] {
        CMD_MEM_NOP   = 2'd0,
        CMD_MEM_READ  = 2'd1,
        CMD_MEM_WRITE = 2'd2,
        CMD_MEM_SPARE = 2'd3
    } cmd_e;

    typedef struct packed {
        logic                      valid;
        logic [BUFFER_9_WIDTH-1:0] buffer_9;
    } descriptor_t;

    typedef struct packed {
        logic [SIZE_WIDTH-1:0] program_size;
        logic [SIZE_WIDTH-1:0] flush_size;
        logic                  flush_enable;
    } setup_params_t;

    // One-cycle start plus the phase it belongs to
    typedef struct packed {
        logic                  start;
        logic                  flush_mode;
        logic [SIZE_WIDTH-1:0] size;
    } phase_cmd_t;

    typedef struct packed {
        cmd_e                  cmd;
        logic [SIZE_WIDTH-1:0] address;
        logic [SIZE_WIDTH-1:0] index;
        logic                  flush_mode;
    } request_payload_t;

    typedef struct packed {
        logic             valid;
        request_payload_t payload;
    } request_t;

    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] data;
    } response_t;

    typedef enum logic [3:0] {
        RESET       = 4'd0,
        IDLE        = 4'd1,
        REQ_START   = 4'd2,
        REQ_BUSY    = 4'd3,
        REQ_PAUSE   = 4'd4,
        REQ_DONE    = 4'd5,
        FLUSH_START = 4'd6,
        FLUSH_BUSY  = 4'd7,
        FLUSH_PAUSE = 4'd8,
        FLUSH_DONE  = 4'd9
    } cu_setup_state_e;

endpackage
